/* logic/rmw_op_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Operation types: word, id, opcode, issue and completion structs,
// opcode helpers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package rmw_op_pkg;

  // Table data word
  typedef logic [31:0] word_t;

  // Table index, 16 words
  typedef logic [3:0] id_t;

  typedef enum logic [1:0] {
    OP_ADD = 2'd0,
    OP_SUB = 2'd1,
    OP_XOR = 2'd2,
    OP_SET = 2'd3
  } op_t;

  // Operation as presented on the issue port
  typedef struct packed {
    id_t   id;
    op_t   op;
    word_t imm;
  } issue_t;

  // Retired result, also the table write
  typedef struct packed {
    id_t   id;
    word_t word;
  } cmpl_t;

  // Set overwrites the word, so the old value is never fetched
  function automatic logic op_needs_lookup(op_t op);
    return (op != OP_SET);
  endfunction

  // New word from old word and immediate, wraps mod 2^32
  function automatic word_t op_apply(op_t op, word_t old_word, word_t imm);
    word_t res;
    case (op)
      OP_ADD:  res = old_word + imm;
      OP_SUB:  res = old_word - imm;
      OP_XOR:  res = old_word ^ imm;
      default: res = imm;
    endcase
    return res;
  endfunction

endpackage

/* logic/rmw_track_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tracker types: entry state, entry struct, lookup and writeback structs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package rmw_track_pkg;

  // Entry index, sized for the default of 8 entries
  typedef logic [2:0] tag_t;

  // One-hot select, one bit per possible tag value
  typedef logic [2**$bits(tag_t)-1:0] ptr_t;

  // Lifetime of an in-flight entry
  typedef enum logic [1:0] {
    ST_AWAIT_WORD = 2'd0,
    ST_RDY        = 2'd1,
    ST_EXEC       = 2'd2,
    ST_COMPLETE   = 2'd3
  } state_t;

  // One tracker slot
  typedef struct packed {
    logic                vld;
    state_t              state;
    rmw_op_pkg::issue_t  issue;
    // Old word after lookup, new word after writeback
    rmw_op_pkg::word_t   word;
  } entry_t;

  // Table read request
  typedef struct packed {
    rmw_op_pkg::id_t id;
    tag_t            tag;
  } lookup_t;

  // Tagged word, used for read returns and exe writebacks
  typedef struct packed {
    tag_t              tag;
    rmw_op_pkg::word_t word;
  } wrbk_t;

endpackage

/* logic/rmw_delay_line.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fixed-latency valid/payload shift register for any payload type
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module rmw_delay_line #(
    parameter int  LATENCY   = 1
  , parameter type payload_t = logic
) (
    input  logic     clk
  , input  logic     rst
  //
  , input  logic     in_vld
  , input  payload_t in_data
  //
  , output logic     out_vld
  , output payload_t out_data
);

  logic [LATENCY-1:0] vld_r;
  payload_t           data_r [LATENCY];

  // Valid chain, cleared by reset
  always_ff @(posedge clk) begin
    if (rst) begin
      vld_r <= '0;
    end else begin
      vld_r[0] <= in_vld;
      for (int i = 1; i < LATENCY; i++)
        vld_r[i] <= vld_r[i-1];
    end
  end

  // Payload only moves with its valid
  always_ff @(posedge clk) begin
    if (in_vld)
      data_r[0] <= in_data;
    for (int i = 1; i < LATENCY; i++)
      if (vld_r[i-1])
        data_r[i] <= data_r[i-1];
  end

  // Last stage drives the output
  assign out_vld  = vld_r[LATENCY-1];
  assign out_data = data_r[LATENCY-1];

endmodule

/* logic/rmw_word_table.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Word table: id-indexed storage, delayed tagged reads, retire writes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module rmw_word_table #(
    parameter int N              = 8
  , parameter int LOOKUP_LATENCY = 3
) (
    input  logic                    clk
  , input  logic                    rst
  //
  , input  logic                    lookup_vld
  , input  rmw_track_pkg::lookup_t  lookup
  //
  , output logic                    rd_vld
  , output rmw_track_pkg::wrbk_t    rd
  //
  , input  logic                    tbl_wr_vld
  , input  rmw_op_pkg::cmpl_t       tbl_wr
);
  import rmw_op_pkg::*;
  import rmw_track_pkg::*;

  // One word per id
  localparam int WORDS = 2**$bits(id_t);
  // Tag bits that actually name an entry
  localparam int ENT_W = (N > 1) ? $clog2(N) : 1;

  word_t mem_r [WORDS];
  wrbk_t rd_req;

  // Storage, all zero out of reset
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < WORDS; i++)
        mem_r[i] <= '0;
    end else if (tbl_wr_vld) begin
      mem_r[tbl_wr.id] <= tbl_wr.word;
    end
  end

  // Read at request time
  // A write in this cycle shows up on the next read
  always_comb begin
    rd_req                 = '0;
    rd_req.tag[ENT_W-1:0]  = lookup.tag[ENT_W-1:0];
    rd_req.word            = mem_r[lookup.id];
  end

  // Long fixed latency back to the tracker
  rmw_delay_line #(
      .LATENCY   (LOOKUP_LATENCY)
    , .payload_t (wrbk_t)
  ) u_rd_pipe (
      .clk      (clk)
    , .rst      (rst)
    , .in_vld   (lookup_vld)
    , .in_data  (rd_req)
    , .out_vld  (rd_vld)
    , .out_data (rd)
  );

endmodule

/* logic/rmw_exec_unit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Multi-cycle execute unit, result and entry tag carried to writeback
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module rmw_exec_unit #(
    parameter int EXE_LATENCY = 4
) (
    input  logic                  clk
  , input  logic                  rst
  //
  , input  logic                  exe_vld
  , input  rmw_op_pkg::issue_t    exe_issue
  , input  rmw_op_pkg::word_t     exe_word
  , input  rmw_track_pkg::tag_t   exe_tag
  //
  , output logic                  wrbk_vld
  , output rmw_track_pkg::wrbk_t  wrbk
);
  import rmw_op_pkg::*;
  import rmw_track_pkg::*;

  // In-flight slot: entry momento plus finished result
  typedef struct packed {
    tag_t  momento;
    word_t result;
  } exe_slot_t;

  exe_slot_t slot_in;
  exe_slot_t slot_out;

  // Arithmetic done on entry
  always_comb begin
    slot_in.momento = exe_tag;
    slot_in.result  = op_apply(exe_issue.op, exe_word, exe_issue.imm);
  end

  // Pipeline depth sets the latency
  // one new op per cycle, up to EXE_LATENCY in flight
  rmw_delay_line #(
      .LATENCY   (EXE_LATENCY)
    , .payload_t (exe_slot_t)
  ) u_exe_pipe (
      .clk      (clk)
    , .rst      (rst)
    , .in_vld   (exe_vld)
    , .in_data  (slot_in)
    , .out_vld  (wrbk_vld)
    , .out_data (slot_out)
  );

  // Momento returns as the writeback tag
  always_comb begin
    wrbk.tag  = slot_out.momento;
    wrbk.word = slot_out.result;
  end

endmodule

/* logic/rmw_tracker.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// In-flight tracker: entry table, allocate/issue/retire pointers, stall
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module rmw_tracker #(
    parameter int N = 8
) (
    input  logic                     clk
  , input  logic                     rst
  //
  , input  logic                     iss_vld
  , input  rmw_op_pkg::issue_t       iss
  , output logic                     iss_rdy
  //
  , output logic                     lookup_vld
  , output rmw_track_pkg::lookup_t   lookup
  , input  logic                     rd_vld
  , input  rmw_track_pkg::wrbk_t     rd
  //
  , output logic                     exe_vld
  , output rmw_op_pkg::issue_t       exe_issue
  , output rmw_op_pkg::word_t        exe_word
  , output rmw_track_pkg::tag_t      exe_tag
  , input  logic                     wrbk_vld
  , input  rmw_track_pkg::wrbk_t     wrbk
  //
  , output logic                     tbl_wr_vld
  , output rmw_op_pkg::cmpl_t        tbl_wr
);
  import rmw_op_pkg::*;
  import rmw_track_pkg::*;

  entry_t [N-1:0] ent_r;
  entry_t [N-1:0] ent_w;
  logic [N-1:0]   alloc_ptr_r;
  logic [N-1:0]   issue_ptr_r;
  logic [N-1:0]   retire_ptr_r;
  logic [N-1:0]   vld_vec;
  logic [N-1:0]   id_hit;
  entry_t         issue_ent;
  entry_t         retire_ent;
  ptr_t           rd_sel;
  ptr_t           wrbk_sel;
  logic           alloc_adv;
  logic           issue_adv;
  logic           retire_adv;

  // One-hot to index
  function automatic tag_t enc_ptr(logic [N-1:0] ptr);
    tag_t tag;
    tag = '0;
    for (int i = 0; i < N; i++)
      if (ptr[i])
        tag = tag_t'(i);
    return tag;
  endfunction

  // Rotate one place, wraps at N
  function automatic logic [N-1:0] rot_ptr(logic [N-1:0] ptr);
    return (ptr << 1) | (ptr >> (N - 1));
  endfunction

  // Entries under the issue and retire pointers
  always_comb begin
    issue_ent  = '0;
    retire_ent = '0;
    for (int i = 0; i < N; i++) begin
      if (issue_ptr_r[i])
        issue_ent = ent_r[i];
      if (retire_ptr_r[i])
        retire_ent = ent_r[i];
    end
  end

  // Full and same-id scan
  always_comb begin
    for (int i = 0; i < N; i++) begin
      vld_vec[i] = ent_r[i].vld;
      id_hit[i]  = ent_r[i].vld & (ent_r[i].issue.id == iss.id);
    end
  end

  // Stall on full or on an id already in flight
  assign iss_rdy    = ~(&vld_vec) & ~(|id_hit);
  assign alloc_adv  = iss_vld & iss_rdy;
  assign issue_adv  = issue_ent.vld & (issue_ent.state == ST_RDY);
  assign retire_adv = retire_ent.vld & (retire_ent.state == ST_COMPLETE);

  // Tags name entries directly
  assign rd_sel   = rd_vld   ? (ptr_t'(1) << rd.tag)   : '0;
  assign wrbk_sel = wrbk_vld ? (ptr_t'(1) << wrbk.tag) : '0;

  // Entry updates
  // each event targets a different state, so at most one hits an entry
  always_comb begin
    for (int i = 0; i < N; i++) begin
      ent_w[i] = ent_r[i];
      if (alloc_adv && alloc_ptr_r[i]) begin
        ent_w[i].vld   = 1'b1;
        ent_w[i].state = op_needs_lookup(iss.op) ? ST_AWAIT_WORD : ST_RDY;
        ent_w[i].issue = iss;
      end
      // Old word returned from the table
      if (rd_sel[i]) begin
        ent_w[i].state = ST_RDY;
        ent_w[i].word  = rd.word;
      end
      if (issue_adv && issue_ptr_r[i])
        ent_w[i].state = ST_EXEC;
      // New word from execute
      if (wrbk_sel[i]) begin
        ent_w[i].state = ST_COMPLETE;
        ent_w[i].word  = wrbk.word;
      end
      if (retire_adv && retire_ptr_r[i])
        ent_w[i].vld = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < N; i++) begin
      if (rst) begin
        ent_r[i].vld   <= 1'b0;
        ent_r[i].state <= ST_AWAIT_WORD;
      end else begin
        ent_r[i] <= ent_w[i];
      end
    end
  end

  // Pointers start at entry 0
  always_ff @(posedge clk) begin
    if (rst) begin
      alloc_ptr_r  <= N'(1);
      issue_ptr_r  <= N'(1);
      retire_ptr_r <= N'(1);
    end else begin
      if (alloc_adv)
        alloc_ptr_r <= rot_ptr(alloc_ptr_r);
      if (issue_adv)
        issue_ptr_r <= rot_ptr(issue_ptr_r);
      if (retire_adv)
        retire_ptr_r <= rot_ptr(retire_ptr_r);
    end
  end

  // Registered valids
  always_ff @(posedge clk) begin
    if (rst) begin
      lookup_vld <= 1'b0;
      exe_vld    <= 1'b0;
      tbl_wr_vld <= 1'b0;
    end else begin
      lookup_vld <= alloc_adv & op_needs_lookup(iss.op);
      exe_vld    <= issue_adv;
      tbl_wr_vld <= retire_adv;
    end
  end

  // Registered payloads, loaded with their valids
  always_ff @(posedge clk) begin
    if (alloc_adv) begin
      lookup.id  <= iss.id;
      lookup.tag <= enc_ptr(alloc_ptr_r);
    end
    if (issue_adv) begin
      exe_issue <= issue_ent.issue;
      exe_word  <= issue_ent.word;
      exe_tag   <= enc_ptr(issue_ptr_r);
    end
    if (retire_adv) begin
      tbl_wr.id   <= retire_ent.issue.id;
      tbl_wr.word <= retire_ent.word;
    end
  end

endmodule

/* logic/rmw_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Read-modify-write unit top: tracker, word table, execute unit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module rmw_top #(
    parameter int N              = 8
  , parameter int LOOKUP_LATENCY = 3
  , parameter int EXE_LATENCY    = 4
) (
    input  logic                clk
  , input  logic                rst
  //
  , input  logic                iss_vld
  , input  rmw_op_pkg::issue_t  iss
  , output logic                iss_rdy
  //
  , output logic                cmpl_vld
  , output rmw_op_pkg::cmpl_t   cmpl
);
  import rmw_op_pkg::*;
  import rmw_track_pkg::*;

  logic    lookup_vld;
  lookup_t lookup;
  logic    rd_vld;
  wrbk_t   rd;
  logic    exe_vld;
  issue_t  exe_issue;
  word_t   exe_word;
  tag_t    exe_tag;
  logic    wrbk_vld;
  wrbk_t   wrbk;
  logic    tbl_wr_vld;
  cmpl_t   tbl_wr;

  rmw_tracker #(.N(N)) u_tracker (
      .clk        (clk)
    , .rst        (rst)
    , .iss_vld    (iss_vld)
    , .iss        (iss)
    , .iss_rdy    (iss_rdy)
    , .lookup_vld (lookup_vld)
    , .lookup     (lookup)
    , .rd_vld     (rd_vld)
    , .rd         (rd)
    , .exe_vld    (exe_vld)
    , .exe_issue  (exe_issue)
    , .exe_word   (exe_word)
    , .exe_tag    (exe_tag)
    , .wrbk_vld   (wrbk_vld)
    , .wrbk       (wrbk)
    , .tbl_wr_vld (tbl_wr_vld)
    , .tbl_wr     (tbl_wr)
  );

  rmw_word_table #(.N(N), .LOOKUP_LATENCY(LOOKUP_LATENCY)) u_table (
      .clk        (clk)
    , .rst        (rst)
    , .lookup_vld (lookup_vld)
    , .lookup     (lookup)
    , .rd_vld     (rd_vld)
    , .rd         (rd)
    , .tbl_wr_vld (tbl_wr_vld)
    , .tbl_wr     (tbl_wr)
  );

  rmw_exec_unit #(.EXE_LATENCY(EXE_LATENCY)) u_exec (
      .clk       (clk)
    , .rst       (rst)
    , .exe_vld   (exe_vld)
    , .exe_issue (exe_issue)
    , .exe_word  (exe_word)
    , .exe_tag   (exe_tag)
    , .wrbk_vld  (wrbk_vld)
    , .wrbk      (wrbk)
  );

  // Retire write doubles as the completion
  assign cmpl_vld = tbl_wr_vld;
  assign cmpl     = tbl_wr;

endmodule

/* verif/rmw_tb_checks.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Expected-word rule, reference table update, ready and completion checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef RMW_TB_CHECKS_SVH
`define RMW_TB_CHECKS_SVH

  // New word per opcode, all of it modulo 2^32
  function automatic word_t expect_word(op_t op, word_t old_word, word_t imm);
    word_t res;
    case (op)
      OP_ADD:  res = old_word + imm;
      OP_SUB:  res = old_word - imm;
      OP_XOR:  res = old_word ^ imm;
      default: res = imm;
    endcase
    return res;
  endfunction

  // Accepted op updates the reference table and queues its completion
  task automatic record_accept(input issue_t req);
    cmpl_t exp;
    exp.id             = req.id;
    exp.word           = expect_word(req.op, model_mem[req.id], req.imm);
    model_mem[req.id]  = exp.word;
    exp_q.push_back(exp);
    inflight_cnt[req.id]++;
    inflight_total++;
  endtask

  // Ready only with a free entry and no same-id op in flight
  task automatic check_rdy();
    logic exp_rdy;
    exp_rdy = (inflight_total < N) && (inflight_cnt[iss.id] == 0);
    if (inflight_total == N)
      full_hits++;
    assert (iss_rdy == exp_rdy)
      else report_failure($sformatf("Fail at %0t: iss_rdy expected %b got %b",
                                    $time, exp_rdy, iss_rdy));
  endtask

  // Completion against the head of the expected queue
  task automatic check_cmpl();
    cmpl_t exp;
    assert (exp_q.size() != 0)
      else report_failure($sformatf("Completion at %0t with no operation outstanding",
                                    $time));
    if (exp_q.size() != 0) begin
      exp = exp_q.pop_front();
      assert (cmpl.id == exp.id)
        else report_failure($sformatf("Fail at %0t: cmpl.id expected %0h got %0h",
                                      $time, exp.id, cmpl.id));
      assert (cmpl.word == exp.word)
        else report_failure($sformatf("Fail at %0t: cmpl.word expected %h got %h",
                                      $time, exp.word, cmpl.word));
      inflight_cnt[exp.id]--;
      inflight_total--;
      last_cmpl = cmpl;
    end
  endtask

`endif

/* verif/rmw_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the RMW unit: clock, reset, stimulus, reference model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module rmw_tb;
  import rmw_op_pkg::*;

  // Default DUT sizing
  localparam int N              = 8;
  localparam int RANDOM_OPS     = 300;
  localparam int TEST_OPS       = 1 + 7 + 6 + (N + 2) + RANDOM_OPS;
  // Roughly 20 cycles worst case per op
  localparam int TIMEOUT_CYCLES = TEST_OPS * 20;

  logic   clk;
  logic   rst;
  logic   iss_vld;
  issue_t iss;
  logic   iss_rdy;
  logic   cmpl_vld;
  cmpl_t  cmpl;

  // Reference state
  word_t  model_mem [16];
  int     inflight_cnt [16];
  int     inflight_total;
  cmpl_t  exp_q [$];
  cmpl_t  last_cmpl;
  int     full_hits;
  int     stall_cnt;
  int     cycle_cnt;
  int     stall_mark;

  rmw_top DUT (
      .clk      (clk)
    , .rst      (rst)
    , .iss_vld  (iss_vld)
    , .iss      (iss)
    , .iss_rdy  (iss_rdy)
    , .cmpl_vld (cmpl_vld)
    , .cmpl     (cmpl)
  );

  // Print the error, then the fail line, then stop
  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1, "stopping at first error");
  endtask

  `include "rmw_tb_checks.svh"

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Run limit
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES)
      report_failure($sformatf("Timeout: run did not finish within %0d cycles",
                               TIMEOUT_CYCLES));
  end

  // First cycle out of reset: ready and no completion
  assert property (@(posedge clk) $fell(rst) |-> (iss_rdy && !cmpl_vld))
    else report_failure($sformatf("Fail at %0t: iss_rdy/cmpl_vld expected 1/0 got %b/%b",
                                  $time, $sampled(iss_rdy), $sampled(cmpl_vld)));

  // Completions sampled mid-cycle
  always @(negedge clk) begin
    if (!rst && cmpl_vld)
      check_cmpl();
  end

  // Offer one op until it is taken
  task automatic send_op(input id_t id, input op_t op, input word_t imm);
    issue_t req;
    logic   done;
    req.id  = id;
    req.op  = op;
    req.imm = imm;
    done    = 1'b0;
    while (!done) begin
      @(negedge clk);
      iss_vld = 1'b1;
      iss     = req;
      // Settle, then sample ready before the rising edge
      #1;
      check_rdy();
      if (iss_rdy) begin
        record_accept(req);
        done = 1'b1;
      end else begin
        stall_cnt++;
      end
    end
  endtask

  task automatic idle_cycle();
    @(negedge clk);
    iss_vld = 1'b0;
    #1;
    check_rdy();
  endtask

  // Wait for every queued completion
  task automatic drain();
    do
      idle_cycle();
    while (exp_q.size() != 0);
  endtask

  initial begin
    void'($urandom(80));
    rst            = 1'b1;
    iss_vld        = 1'b0;
    iss            = '0;
    inflight_total = 0;
    full_hits      = 0;
    stall_cnt      = 0;
    cycle_cnt      = 0;
    last_cmpl      = '0;
    for (int i = 0; i < 16; i++) begin
      model_mem[i]    = '0;
      inflight_cnt[i] = 0;
    end
    repeat (8) @(negedge clk);
    rst = 1'b0;

    // Fresh word is zero, so add returns the immediate
    send_op(4'd5, OP_ADD, 32'h1234_5678);
    drain();
    assert (last_cmpl.word == 32'h1234_5678)
      else report_failure($sformatf("Fail at %0t: cmpl.word expected %h got %h",
                                    $time, 32'h1234_5678, last_cmpl.word));

    // Every opcode, two ids interleaved, wrap on sub
    send_op(4'd3, OP_ADD, 32'h0000_0100);
    send_op(4'd9, OP_SUB, 32'h0000_0001);
    send_op(4'd3, OP_SUB, 32'h0000_0030);
    send_op(4'd9, OP_XOR, 32'h0f0f_0f0f);
    send_op(4'd3, OP_XOR, 32'hffff_0000);
    send_op(4'd3, OP_SET, 32'hcafe_f00d);
    send_op(4'd3, OP_SUB, 32'hffff_ffff);
    drain();

    // Same-id burst must stall
    stall_mark = stall_cnt;
    for (int k = 0; k < 6; k++)
      send_op(4'd7, op_t'(2'(k)), word_t'(32'h0101_0101 * (k + 1)));
    drain();
    assert (stall_cnt > stall_mark)
      else report_failure("Same-id burst never saw iss_rdy low");

    // Distinct ids back to back, enough to fill the tracker
    for (int k = 0; k < N + 2; k++)
      send_op(id_t'(k), OP_ADD, word_t'(k * 3 + 1));
    drain();
    assert (full_hits > 0)
      else report_failure("Tracker never reached full occupancy");

    // Random stream with gaps
    for (int k = 0; k < RANDOM_OPS; k++) begin
      if ($urandom_range(0, 3) == 0)
        idle_cycle();
      send_op(id_t'($urandom_range(0, 15)), op_t'(2'($urandom_range(0, 3))), $urandom);
    end
    drain();

    // Quiet tail, any late completion hits the empty-queue check
    repeat (10) idle_cycle();
    if (exp_q.size() == 0) begin
      $display("ALL CHECKS PASSED");
      $finish;
    end else begin
      report_failure($sformatf("Run ended with %0d completions outstanding",
                               exp_q.size()));
    end
  end

endmodule

/* project.f */
+incdir+verif
logic/rmw_op_pkg.sv
logic/rmw_track_pkg.sv
logic/rmw_delay_line.sv
logic/rmw_word_table.sv
logic/rmw_exec_unit.sv
logic/rmw_tracker.sv
logic/rmw_top.sv
verif/rmw_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the RMW testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f project.f --top-module rmw_tb -o rmw_sim || exit 1
sim_out="$(./obj_dir/rmw_sim 2>&1)"
echo "$sim_out"
echo "$sim_out" | grep -q "ALL CHECKS PASSED" && echo "Simulation passed" || {
  echo "Simulation failed"
  exit 1
}
